// ==== Makefile ====
# Verilator build and run for the VGA front end

VERILATOR ?= verilator
TOP       ?= tb_vga_controller
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
LOG       ?= sim.log

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
common/vga_pkg.sv
verilog/video_timing.sv
menu/menu_fsm.sv
menu/slot_select.sv
verilog/pixel_painter.sv
verilog/vga_controller.sv
testbench/vga_controller_props.sv
testbench/tb_vga_controller.sv

// ==== common/vga_pkg.sv ====
package vga_pkg;

	////////////////////////////////////////////////////////////
	// video timing, 640x480 at 60 Hz

	localparam int H_VISIBLE = 640;
	localparam int H_FRONT   = 16;
	localparam int H_SYNC    = 96;
	localparam int H_BACK    = 48;
	localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;

	localparam int V_VISIBLE = 480;
	localparam int V_FRONT   = 10;
	localparam int V_SYNC    = 2;
	localparam int V_BACK    = 33;
	localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

	// first count of each sync pulse
	localparam int H_SYNC_START = H_VISIBLE + H_FRONT;
	localparam int V_SYNC_START = V_VISIBLE + V_FRONT;

	typedef logic [9:0] coord_t;

	////////////////////////////////////////////////////////////
	// screens, modes and menu buttons

	typedef enum logic [1:0] {
		SCR_SPLASH = 2'd0,
		SCR_MAIN   = 2'd1,
		SCR_SL     = 2'd2,
		SCR_GAME   = 2'd3
	} screen_t;

	typedef enum logic [2:0] {
		MODE_SPLASH = 3'd0,
		MODE_MAIN   = 3'd1,
		MODE_SAVE   = 3'd2,
		MODE_LOAD   = 3'd3,
		MODE_GAME   = 3'd4
	} mode_t;

	// in the main menu slot1/2/3 double as save/load/game
	localparam int BTN_BACK  = 0;
	localparam int BTN_SLOT1 = 1;
	localparam int BTN_SLOT2 = 2;
	localparam int BTN_SLOT3 = 3;

	localparam int SENSOR_W = 32;

	typedef logic [31:0] slot_t;

	localparam slot_t SLOT_NONE = 32'd0;
	localparam slot_t SLOT_1    = 32'd1;
	localparam slot_t SLOT_2    = 32'd2;
	localparam slot_t SLOT_3    = 32'd3;

	////////////////////////////////////////////////////////////
	// colors, packed as {blue, green, red}

	typedef logic [23:0] rgb_t;

	localparam rgb_t COLOR_LIGHT_GREEN = 24'h90EE90;
	localparam rgb_t COLOR_DARK_GREEN  = 24'h006400;
	localparam rgb_t COLOR_WHITE       = 24'hFFFFFF;

	localparam rgb_t BG_SPLASH = 24'h802010;
	localparam rgb_t BG_MAIN   = 24'h503018;
	localparam rgb_t BG_SL     = 24'h404080;
	localparam rgb_t BG_GAME   = 24'h201040;

	// rectangle bounds, all exclusive
	localparam int HIT_X_LO = 154;
	localparam int HIT_X_HI = 193;
	localparam int HIT_Y_LO = 198;
	localparam int HIT_Y_HI = 247;

	// score banner on main
	localparam int MAIN_TOP_X_LO = 75;
	localparam int MAIN_TOP_X_HI = 572;
	localparam int MAIN_TOP_Y_LO = 60;
	localparam int MAIN_TOP_Y_HI = 98;

	// back corner on main, open towards the origin
	localparam int MAIN_BACK_X_HI = 75;
	localparam int MAIN_BACK_Y_HI = 33;

	// menu column, shared by main and save/load
	localparam int MENU_X_LO = 11;
	localparam int MENU_X_HI = 125;
	localparam int MENU_Y_LO = 286;
	localparam int MENU_Y_HI = 381;

	localparam int SL_TOP_X_LO = 82;
	localparam int SL_TOP_X_HI = 562;
	localparam int SL_TOP_Y_LO = 0;
	localparam int SL_TOP_Y_HI = 57;

	localparam int GAME_TOP_X_LO = 71;
	localparam int GAME_TOP_X_HI = 573;
	localparam int GAME_TOP_Y_LO = 0;
	localparam int GAME_TOP_Y_HI = 97;

	// point strictly inside a rectangle
	function automatic logic in_box(input coord_t px, input coord_t py,
		input int x_lo, input int x_hi, input int y_lo, input int y_hi);
		return (px > x_lo) && (px < x_hi) && (py > y_lo) && (py < y_hi);
	endfunction

endpackage

// ==== menu/menu_fsm.sv ====
`timescale 1ns/1ps

module menu_fsm (
	input  logic                         VGA_CLK_n,
	input  logic                         iRST_n,
	input  logic [3:0]                   controller,
	input  logic [vga_pkg::SENSOR_W-1:0] sensor_input,
	output vga_pkg::screen_t             screen,
	output logic                         save_active,
	output logic                         load_active,
	output logic [vga_pkg::SENSOR_W-1:0] sensor_input_to_save
);

	vga_pkg::mode_t mode;
	logic           any_btn;
	logic           back_btn;

	assign any_btn  = |controller;
	assign back_btn = controller[vga_pkg::BTN_BACK];

	////////////////////////////////////////////////////////////
	// mode transitions

	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			mode <= vga_pkg::MODE_SPLASH;
		end else begin
			case (mode)
				vga_pkg::MODE_SPLASH: begin
					if (any_btn) begin
						mode <= vga_pkg::MODE_MAIN;
					end
				end
				// load wins over save, save over game
				vga_pkg::MODE_MAIN: begin
					if (controller[vga_pkg::BTN_SLOT2]) begin
						mode <= vga_pkg::MODE_LOAD;
					end else if (controller[vga_pkg::BTN_SLOT1]) begin
						mode <= vga_pkg::MODE_SAVE;
					end else if (controller[vga_pkg::BTN_SLOT3]) begin
						mode <= vga_pkg::MODE_GAME;
					end
				end
				vga_pkg::MODE_SAVE, vga_pkg::MODE_LOAD, vga_pkg::MODE_GAME: begin
					if (back_btn) begin
						mode <= vga_pkg::MODE_MAIN;
					end
				end
				default: mode <= vga_pkg::MODE_MAIN;
			endcase
		end
	end

	// save and load share one screen
	always_comb begin
		case (mode)
			vga_pkg::MODE_MAIN: screen = vga_pkg::SCR_MAIN;
			vga_pkg::MODE_SAVE: screen = vga_pkg::SCR_SL;
			vga_pkg::MODE_LOAD: screen = vga_pkg::SCR_SL;
			vga_pkg::MODE_GAME: screen = vga_pkg::SCR_GAME;
			default:            screen = vga_pkg::SCR_SPLASH;
		endcase
	end

	assign save_active = (mode == vga_pkg::MODE_SAVE);
	assign load_active = (mode == vga_pkg::MODE_LOAD);

	// sensor snapshot follows the pads while saving
	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			sensor_input_to_save <= '0;
		end else if (save_active && !back_btn) begin
			sensor_input_to_save <= sensor_input;
		end
	end

endmodule

// ==== menu/slot_select.sv ====
`timescale 1ns/1ps

module slot_select (
	input  logic           VGA_CLK_n,
	input  logic           iRST_n,
	input  logic           active,
	input  logic [3:0]     controller,
	output vga_pkg::slot_t slot
);

	////////////////////////////////////////////////////////////
	// slot register, one per session kind

	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			slot <= vga_pkg::SLOT_NONE;
		end else if (!active) begin
			// session over, next one starts empty
			slot <= vga_pkg::SLOT_NONE;
		end else if (controller[vga_pkg::BTN_SLOT1]) begin
			slot <= vga_pkg::SLOT_1;
		end else if (controller[vga_pkg::BTN_SLOT2]) begin
			slot <= vga_pkg::SLOT_2;
		end else if (controller[vga_pkg::BTN_SLOT3]) begin
			slot <= vga_pkg::SLOT_3;
		end
		// no slot button, keep the choice
	end

endmodule

// ==== testbench/tb_vga_controller.sv ====
`timescale 1ns/1ps

module tb_vga_controller;

	logic                         VGA_CLK_n;
	logic                         iRST_n;
	logic [3:0]                   controller;
	logic [vga_pkg::SENSOR_W-1:0] sensor_input;
	logic                         hs;
	logic                         vs;
	logic                         blank_n;
	logic [7:0]                   r_data;
	logic [7:0]                   g_data;
	logic [7:0]                   b_data;
	vga_pkg::slot_t               save_signal;
	vga_pkg::slot_t               load_signal;
	logic [vga_pkg::SENSOR_W-1:0] sensor_input_to_save;

	logic [31:0] lfsr;
	int          timeouts;
	int          tests_run;
	int          tests_failed;
	int          errors_before;

	vga_controller vga_controller_i (
		.VGA_CLK_n            (VGA_CLK_n),
		.iRST_n               (iRST_n),
		.controller           (controller),
		.sensor_input         (sensor_input),
		.hs                   (hs),
		.vs                   (vs),
		.blank_n              (blank_n),
		.r_data               (r_data),
		.g_data               (g_data),
		.b_data               (b_data),
		.save_signal          (save_signal),
		.load_signal          (load_signal),
		.sensor_input_to_save (sensor_input_to_save)
	);

	always #2 VGA_CLK_n = ~VGA_CLK_n;

	////////////////////////////////////////////////////////////
	// stimulus helpers

	// galois form, taps of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end
		return s >> 1;
	endfunction

	task automatic take_random(output logic [31:0] word);
		word = '0;
		for (int i = 0; i < 32; i++) begin
			lfsr = lfsr_next(lfsr);
			word = {word[30:0], lfsr[0]};
		end
	endtask

	// all helpers start and end 0.5 ns after a rising edge
	task automatic run_cycles(input int n, input bit shuffle);
		logic [31:0] word;
		for (int i = 0; i < n; i++) begin
			if (shuffle) begin
				take_random(word);
				sensor_input = word;
			end
			@(posedge VGA_CLK_n);
			#0.5;
		end
	endtask

	task automatic press(input int btn);
		controller = 4'b0000;
		controller[btn] = 1'b1;
		@(posedge VGA_CLK_n);
		#0.5;
		controller = 4'b0000;
	endtask

	task automatic wait_vs_fall(input string what);
		int  n;
		logic prev;
		logic fell;
		n = 0;
		prev = vs;
		fell = 1'b0;
		while (!fell && n < vga_pkg::V_TOTAL * vga_pkg::H_TOTAL + 16) begin
			@(posedge VGA_CLK_n);
			#0.5;
			n++;
			fell = prev && !vs;
			prev = vs;
		end
		if (!fell) begin
			timeouts++;
			$display("timeout: vs never fell while %0s", what);
		end
	endtask

	// pads hold still for a whole frame
	task automatic show_pads(input logic [4:0] pads);
		logic [31:0] word;
		take_random(word);
		sensor_input = {word[31:5], pads};
		wait_vs_fall("settling the pads");
		wait_vs_fall("painting a frame");
	endtask

	function automatic int errors_so_far();
		return vga_controller_i.props_i.fail_count + timeouts;
	endfunction

	task automatic end_test(input string name);
		int errs;
		errs = errors_so_far() - errors_before;
		tests_run++;
		if (errs != 0) begin
			tests_failed++;
		end
		$display("test %0s finished, %0d errors", name, errs);
		errors_before = errors_so_far();
	endtask

	////////////////////////////////////////////////////////////
	// test sequence

	initial begin
		VGA_CLK_n     = 1'b0;
		iRST_n        = 1'b0;
		controller    = 4'b0000;
		sensor_input  = '1;
		lfsr          = 32'h9818;
		timeouts      = 0;
		tests_run     = 0;
		tests_failed  = 0;
		errors_before = 0;
		repeat (2) @(posedge VGA_CLK_n);
		#0.5;
		iRST_n = 1'b1;

		// two whole frames of splash between three vs falls
		wait_vs_fall("waiting for frame 1");
		wait_vs_fall("waiting for frame 2");
		wait_vs_fall("waiting for frame 3");
		end_test("sync_and_blanking");

		press(vga_pkg::BTN_BACK);
		run_cycles(3, 1'b0);
		press(vga_pkg::BTN_SLOT1);
		run_cycles(8, 1'b1);
		press(vga_pkg::BTN_SLOT2);
		run_cycles(4, 1'b1);
		press(vga_pkg::BTN_BACK);
		run_cycles(4, 1'b0);
		end_test("menu_and_save_slot");

		press(vga_pkg::BTN_SLOT2);
		run_cycles(3, 1'b0);
		press(vga_pkg::BTN_SLOT3);
		run_cycles(3, 1'b0);
		press(vga_pkg::BTN_BACK);
		run_cycles(4, 1'b0);
		end_test("load_slot");

		show_pads(5'b11110);
		show_pads(5'b01111);
		show_pads(5'b11111);
		press(vga_pkg::BTN_SLOT3);
		wait_vs_fall("entering game");
		wait_vs_fall("painting game");
		press(vga_pkg::BTN_BACK);
		run_cycles(4, 1'b0);
		end_test("pixel_colors");

		$display("%0d tests run, %0d failed, %0d assertion errors, %0d timeouts",
			tests_run, tests_failed, vga_controller_i.props_i.fail_count, timeouts);
		if (tests_failed == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== testbench/vga_controller_props.sv ====
`timescale 1ns/1ps

module vga_controller_props (
	input logic                         VGA_CLK_n,
	input logic                         iRST_n,
	input logic [3:0]                   controller,
	input logic [vga_pkg::SENSOR_W-1:0] sensor_input,
	input logic                         hs,
	input logic                         vs,
	input logic                         blank_n,
	input logic [7:0]                   r_data,
	input logic [7:0]                   g_data,
	input logic [7:0]                   b_data,
	input vga_pkg::slot_t               save_signal,
	input vga_pkg::slot_t               load_signal,
	input logic [vga_pkg::SENSOR_W-1:0] sensor_input_to_save,
	input vga_pkg::coord_t              x,
	input vga_pkg::coord_t              y,
	input vga_pkg::screen_t             screen,
	input logic                         save_active,
	input logic                         load_active
);

	int                           fail_count = 0;
	logic                         hs_q;
	logic                         vs_q;
	logic                         blank_q;
	logic                         hs_seen;
	logic                         vs_seen;
	int                           hs_gap;
	int                           hs_low;
	int                           vs_gap;
	int                           blank_len;
	vga_pkg::coord_t              x_q;
	vga_pkg::coord_t              y_q;
	vga_pkg::screen_t             screen_q;
	logic [vga_pkg::SENSOR_W-1:0] sens_q;
	vga_pkg::rgb_t                rgb;
	logic                         at_hit_probe;
	logic                         at_game_probe;

	assign rgb = {b_data, g_data, r_data};

	// pixel probes, one cycle behind the counters like the color
	assign at_hit_probe  = screen_q == vga_pkg::SCR_MAIN && x_q == 10'd170 && y_q == 10'd220;
	assign at_game_probe = screen_q == vga_pkg::SCR_GAME && x_q == 10'd100 && y_q == 10'd50;

	// inner pads win over the fifth one
	function automatic vga_pkg::rgb_t hit_color(input logic [4:0] pads);
		if (pads[3:0] != 4'hF) begin
			return vga_pkg::COLOR_LIGHT_GREEN;
		end
		if (!pads[4]) begin
			return vga_pkg::COLOR_DARK_GREEN;
		end
		return vga_pkg::BG_MAIN;
	endfunction

	////////////////////////////////////////////////////////////
	// edge trackers and pulse lengths

	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			hs_q      <= 1'b1;
			vs_q      <= 1'b1;
			blank_q   <= 1'b0;
			hs_seen   <= 1'b0;
			vs_seen   <= 1'b0;
			hs_gap    <= 0;
			hs_low    <= 0;
			vs_gap    <= 0;
			blank_len <= 0;
		end else begin
			hs_q      <= hs;
			vs_q      <= vs;
			blank_q   <= blank_n;
			hs_low    <= hs ? 0 : hs_low + 1;
			blank_len <= blank_n ? blank_len + 1 : 0;
			if (hs_q && !hs) begin
				hs_gap  <= 1;
				hs_seen <= 1'b1;
			end else begin
				hs_gap <= hs_gap + 1;
			end
			if (vs_q && !vs) begin
				vs_gap  <= 1;
				vs_seen <= 1'b1;
			end else begin
				vs_gap <= vs_gap + 1;
			end
		end
	end

	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			x_q      <= '0;
			y_q      <= '0;
			screen_q <= vga_pkg::SCR_SPLASH;
			sens_q   <= '0;
		end else begin
			x_q      <= x;
			y_q      <= y;
			screen_q <= screen;
			sens_q   <= sensor_input;
		end
	end

	////////////////////////////////////////////////////////////
	// video timing

	assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		(hs && !hs_q) |-> (hs_low == vga_pkg::H_SYNC)) else begin
		$error("error hs_low_cycles %h expected %h", $sampled(hs_low), vga_pkg::H_SYNC);
		fail_count++;
	end

	assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		(hs_seen && hs_q && !hs) |-> (hs_gap == vga_pkg::H_TOTAL)) else begin
		$error("error hs_period %h expected %h", $sampled(hs_gap), vga_pkg::H_TOTAL);
		fail_count++;
	end

	assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		(vs_seen && vs_q && !vs) |-> (vs_gap == vga_pkg::V_TOTAL * vga_pkg::H_TOTAL)) else begin
		$error("error vs_period %h expected %h", $sampled(vs_gap),
			vga_pkg::V_TOTAL * vga_pkg::H_TOTAL);
		fail_count++;
	end

	assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		(blank_q && !blank_n) |-> (blank_len == vga_pkg::H_VISIBLE)) else begin
		$error("error blank_n_high_cycles %h expected %h", $sampled(blank_len),
			vga_pkg::H_VISIBLE);
		fail_count++;
	end

	assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		!blank_n |-> (rgb == 24'h0)) else begin
		$error("error rgb %h expected %h while blanked", $sampled(rgb), 24'h0);
		fail_count++;
	end

	////////////////////////////////////////////////////////////
	// menu, slots and sensor capture

	assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		(screen == vga_pkg::SCR_SPLASH && |controller) |=> (screen == vga_pkg::SCR_MAIN)) else begin
		$error("error screen %h expected %h", $sampled(screen), vga_pkg::SCR_MAIN);
		fail_count++;
	end

	// main menu buttons, load over save and save over game
	assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		(screen == vga_pkg::SCR_MAIN && controller[vga_pkg::BTN_SLOT2])
		|=> load_active) else begin
		$error("error load_active %h expected %h", $sampled(load_active), 1'b1);
		fail_count++;
	end

	assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		(screen == vga_pkg::SCR_MAIN && controller[vga_pkg::BTN_SLOT1] &&
		!controller[vga_pkg::BTN_SLOT2]) |=> save_active) else begin
		$error("error save_active %h expected %h", $sampled(save_active), 1'b1);
		fail_count++;
	end

	assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		(screen == vga_pkg::SCR_MAIN && controller[vga_pkg::BTN_SLOT3] &&
		!controller[vga_pkg::BTN_SLOT2] && !controller[vga_pkg::BTN_SLOT1])
		|=> (screen == vga_pkg::SCR_GAME)) else begin
		$error("error screen %h expected %h", $sampled(screen), vga_pkg::SCR_GAME);
		fail_count++;
	end

	// back leaves save, load and game
	assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		((screen == vga_pkg::SCR_SL || screen == vga_pkg::SCR_GAME) &&
		controller[vga_pkg::BTN_BACK]) |=> (screen == vga_pkg::SCR_MAIN)) else begin
		$error("error screen %h expected %h", $sampled(screen), vga_pkg::SCR_MAIN);
		fail_count++;
	end

	assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		(save_active && controller[vga_pkg::BTN_SLOT2] && !controller[vga_pkg::BTN_SLOT1])
		|=> (save_signal == vga_pkg::SLOT_2)) else begin
		$error("error save_signal %h expected %h", $sampled(save_signal), vga_pkg::SLOT_2);
		fail_count++;
	end

	assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		(load_active && controller[vga_pkg::BTN_SLOT3] && !controller[vga_pkg::BTN_SLOT2] &&
		!controller[vga_pkg::BTN_SLOT1]) |=> (load_signal == vga_pkg::SLOT_3)) else begin
		$error("error load_signal %h expected %h", $sampled(load_signal), vga_pkg::SLOT_3);
		fail_count++;
	end

	// a session that is not running shows no slot
	assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		!save_active |=> (save_signal == vga_pkg::SLOT_NONE)) else begin
		$error("error save_signal %h expected %h", $sampled(save_signal), vga_pkg::SLOT_NONE);
		fail_count++;
	end

	assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		!load_active |=> (load_signal == vga_pkg::SLOT_NONE)) else begin
		$error("error load_signal %h expected %h", $sampled(load_signal), vga_pkg::SLOT_NONE);
		fail_count++;
	end

	assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		(save_active && !controller[vga_pkg::BTN_BACK]) |=> (sensor_input_to_save == sens_q))
		else begin
		$error("error sensor_input_to_save %h expected %h", $sampled(sensor_input_to_save),
			$sampled(sens_q));
		fail_count++;
	end

	////////////////////////////////////////////////////////////
	// pixel colors

	assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		(blank_n && screen_q == vga_pkg::SCR_SPLASH) |-> (rgb == vga_pkg::BG_SPLASH)) else begin
		$error("error rgb %h expected %h on splash", $sampled(rgb), vga_pkg::BG_SPLASH);
		fail_count++;
	end

	assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		at_game_probe |-> (rgb == vga_pkg::COLOR_WHITE)) else begin
		$error("error rgb %h expected %h on game mask", $sampled(rgb), vga_pkg::COLOR_WHITE);
		fail_count++;
	end

	assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		at_hit_probe |-> (rgb == hit_color(sens_q[4:0]))) else begin
		$error("error rgb %h expected %h in hit box", $sampled(rgb),
			hit_color($sampled(sens_q[4:0])));
		fail_count++;
	end

endmodule

bind vga_controller vga_controller_props props_i (.*);

// ==== verilog/pixel_painter.sv ====
`timescale 1ns/1ps

module pixel_painter (
	input  logic                         VGA_CLK_n,
	input  logic                         iRST_n,
	input  vga_pkg::coord_t              x,
	input  vga_pkg::coord_t              y,
	input  logic                         active,
	input  logic                         hs_raw,
	input  logic                         vs_raw,
	input  vga_pkg::screen_t             screen,
	input  logic [vga_pkg::SENSOR_W-1:0] sensor_input,
	output logic [7:0]                   r_data,
	output logic [7:0]                   g_data,
	output logic [7:0]                   b_data,
	output logic                         hs,
	output logic                         vs,
	output logic                         blank_n
);

	vga_pkg::rgb_t color_next;
	vga_pkg::rgb_t color_q;
	logic          in_hit;
	logic          in_menu;

	assign in_hit = vga_pkg::in_box(x, y, vga_pkg::HIT_X_LO, vga_pkg::HIT_X_HI,
		vga_pkg::HIT_Y_LO, vga_pkg::HIT_Y_HI);
	assign in_menu = vga_pkg::in_box(x, y, vga_pkg::MENU_X_LO, vga_pkg::MENU_X_HI,
		vga_pkg::MENU_Y_LO, vga_pkg::MENU_Y_HI);

	////////////////////////////////////////////////////////////
	// color choice, later layers override earlier ones

	always_comb begin
		color_next = '0;
		if (active) begin
			case (screen)
				vga_pkg::SCR_MAIN: color_next = vga_pkg::BG_MAIN;
				vga_pkg::SCR_SL:   color_next = vga_pkg::BG_SL;
				vga_pkg::SCR_GAME: color_next = vga_pkg::BG_GAME;
				default:           color_next = vga_pkg::BG_SPLASH;
			endcase

			// hit box, pads are active low
			if (screen != vga_pkg::SCR_SPLASH && in_hit) begin
				if (!(&sensor_input[3:0])) begin
					color_next = vga_pkg::COLOR_LIGHT_GREEN;
				end else if (!sensor_input[4]) begin
					color_next = vga_pkg::COLOR_DARK_GREEN;
				end
			end

			// white masks over the image areas
			case (screen)
				vga_pkg::SCR_MAIN: begin
					if (vga_pkg::in_box(x, y, vga_pkg::MAIN_TOP_X_LO, vga_pkg::MAIN_TOP_X_HI,
						vga_pkg::MAIN_TOP_Y_LO, vga_pkg::MAIN_TOP_Y_HI) || in_menu ||
						(x < vga_pkg::MAIN_BACK_X_HI && y < vga_pkg::MAIN_BACK_Y_HI)) begin
						color_next = vga_pkg::COLOR_WHITE;
					end
				end
				vga_pkg::SCR_SL: begin
					if (vga_pkg::in_box(x, y, vga_pkg::SL_TOP_X_LO, vga_pkg::SL_TOP_X_HI,
						vga_pkg::SL_TOP_Y_LO, vga_pkg::SL_TOP_Y_HI) || in_menu) begin
						color_next = vga_pkg::COLOR_WHITE;
					end
				end
				vga_pkg::SCR_GAME: begin
					if (vga_pkg::in_box(x, y, vga_pkg::GAME_TOP_X_LO, vga_pkg::GAME_TOP_X_HI,
						vga_pkg::GAME_TOP_Y_LO, vga_pkg::GAME_TOP_Y_HI)) begin
						color_next = vga_pkg::COLOR_WHITE;
					end
				end
				default: ;
			endcase
		end
	end

	// color, sync and blank share one register stage
	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			color_q <= '0;
			hs      <= 1'b1;
			vs      <= 1'b1;
			blank_n <= 1'b0;
		end else begin
			color_q <= color_next;
			hs      <= hs_raw;
			vs      <= vs_raw;
			blank_n <= active;
		end
	end

	assign b_data = color_q[23:16];
	assign g_data = color_q[15:8];
	assign r_data = color_q[7:0];

endmodule

// ==== verilog/vga_controller.sv ====
`timescale 1ns/1ps

module vga_controller (
	input  logic                         VGA_CLK_n,
	input  logic                         iRST_n,
	input  logic [3:0]                   controller,
	input  logic [vga_pkg::SENSOR_W-1:0] sensor_input,
	output logic                         hs,
	output logic                         vs,
	output logic                         blank_n,
	output logic [7:0]                   r_data,
	output logic [7:0]                   g_data,
	output logic [7:0]                   b_data,
	output vga_pkg::slot_t               save_signal,
	output vga_pkg::slot_t               load_signal,
	output logic [vga_pkg::SENSOR_W-1:0] sensor_input_to_save
);

	vga_pkg::coord_t  x;
	vga_pkg::coord_t  y;
	logic             active;
	logic             hs_raw;
	logic             vs_raw;
	vga_pkg::screen_t screen;
	logic             save_active;
	logic             load_active;

	video_timing video_timing_i (
		.VGA_CLK_n (VGA_CLK_n),
		.iRST_n    (iRST_n),
		.x         (x),
		.y         (y),
		.active    (active),
		.hs_raw    (hs_raw),
		.vs_raw    (vs_raw)
	);

	menu_fsm menu_fsm_i (
		.VGA_CLK_n            (VGA_CLK_n),
		.iRST_n               (iRST_n),
		.controller           (controller),
		.sensor_input         (sensor_input),
		.screen               (screen),
		.save_active          (save_active),
		.load_active          (load_active),
		.sensor_input_to_save (sensor_input_to_save)
	);

	////////////////////////////////////////////////////////////
	// one slot register per session kind

	slot_select save_slot_i (
		.VGA_CLK_n  (VGA_CLK_n),
		.iRST_n     (iRST_n),
		.active     (save_active),
		.controller (controller),
		.slot       (save_signal)
	);

	slot_select load_slot_i (
		.VGA_CLK_n  (VGA_CLK_n),
		.iRST_n     (iRST_n),
		.active     (load_active),
		.controller (controller),
		.slot       (load_signal)
	);

	pixel_painter pixel_painter_i (
		.VGA_CLK_n    (VGA_CLK_n),
		.iRST_n       (iRST_n),
		.x            (x),
		.y            (y),
		.active       (active),
		.hs_raw       (hs_raw),
		.vs_raw       (vs_raw),
		.screen       (screen),
		.sensor_input (sensor_input),
		.r_data       (r_data),
		.g_data       (g_data),
		.b_data       (b_data),
		.hs           (hs),
		.vs           (vs),
		.blank_n      (blank_n)
	);

endmodule

// ==== verilog/video_timing.sv ====
`timescale 1ns/1ps

module video_timing (
	input  logic            VGA_CLK_n,
	input  logic            iRST_n,
	output vga_pkg::coord_t x,
	output vga_pkg::coord_t y,
	output logic            active,
	output logic            hs_raw,
	output logic            vs_raw
);

	vga_pkg::coord_t h_cnt;
	vga_pkg::coord_t v_cnt;
	logic            h_wrap;
	logic            v_wrap;

	assign h_wrap = (h_cnt == vga_pkg::coord_t'(vga_pkg::H_TOTAL - 1));
	assign v_wrap = (v_cnt == vga_pkg::coord_t'(vga_pkg::V_TOTAL - 1));

	////////////////////////////////////////////////////////////
	// pixel and line counters

	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			h_cnt <= '0;
		end else if (h_wrap) begin
			h_cnt <= '0;
		end else begin
			h_cnt <= h_cnt + 10'd1;
		end
	end

	// line count steps once per horizontal wrap
	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			v_cnt <= '0;
		end else if (h_wrap) begin
			if (v_wrap) begin
				v_cnt <= '0;
			end else begin
				v_cnt <= v_cnt + 10'd1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// window decode

	assign x = h_cnt;
	assign y = v_cnt;

	assign active = (h_cnt < vga_pkg::H_VISIBLE) && (v_cnt < vga_pkg::V_VISIBLE);

	// both syncs are active low
	assign hs_raw = !((h_cnt >= vga_pkg::H_SYNC_START) &&
		(h_cnt < vga_pkg::H_SYNC_START + vga_pkg::H_SYNC));
	assign vs_raw = !((v_cnt >= vga_pkg::V_SYNC_START) &&
		(v_cnt < vga_pkg::V_SYNC_START + vga_pkg::V_SYNC));

endmodule
